/* hdl/cache_geom_pkg.sv */
// Cache geometry: address field widths, set and way counts, line and word types
package cache_geom_pkg;

	localparam int ADDR_W     = 32;
	localparam int WAY_N      = 4;
	localparam int SET_N      = 16;

	// Address fields, low to high: offset | index | tag
	localparam int OFFSET_W   = 6;	// 64 byte line
	localparam int INDEX_W    = 4;
	localparam int TAG_W      = 22;

	// Word in line, address bits 5..3
	localparam int WORD_SEL_W = 3;

	typedef logic [ADDR_W-1:0]          addr_t;
	typedef logic [TAG_W-1:0]           tag_t;
	typedef logic [INDEX_W-1:0]         set_idx_t;
	typedef logic [$clog2(WAY_N)-1:0]   way_t;
	typedef logic [WORD_SEL_W-1:0]      word_sel_t;

	// One full line, 8 bits per byte of offset range
	typedef logic [8*(2**OFFSET_W)-1:0] line_t;

	// One read word, eight per line
	typedef logic [63:0]                word_t;

endpackage

/* hdl/cache_ctrl_pkg.sv */
// Cache control: way status enum, read credit depth and aging period
package cache_ctrl_pkg;

	// Ordered so that a lower value is a better victim
	typedef enum logic [1:0] {
		ST_INVALID = 2'd0,
		ST_OLD     = 2'd1,
		ST_RECENT  = 2'd2,
		ST_FRESH   = 2'd3
	} way_status_e;

	// Read response credits after reset
	localparam int CREDIT_N   = 4;
	localparam int CREDIT_W   = 3;	// Holds 0..CREDIT_N

	// Cycles between aging steps
	localparam int AGE_PERIOD = 64;

endpackage

/* hdl/l1_tag_store.sv */
// Tag and status arrays with hit compare, victim choice, aging timer and fill/touch/remove updates
`timescale 1ns/10ps

module l1_tag_store (
	input  logic                  iCLOCK,
	input  logic                  inRESET,
	input  logic                  remove,
	input  logic                  lookup_en,
	input  cache_geom_pkg::addr_t lookup_addr,
	input  logic                  wr_req,
	input  cache_geom_pkg::addr_t wr_addr,
	output logic                  hit,
	output cache_geom_pkg::way_t  hit_way,
	output cache_geom_pkg::way_t  fill_way
);
	import cache_geom_pkg::*;
	import cache_ctrl_pkg::*;

	localparam int AGE_W = $clog2(AGE_PERIOD);

	tag_t        tag_mem [SET_N][WAY_N];
	way_status_e status  [SET_N][WAY_N];

	set_idx_t    lk_set;
	tag_t        lk_tag;
	logic        lk_hit;
	way_t        lk_way;

	set_idx_t    wr_set;
	tag_t        wr_tag;
	logic        wr_match;
	way_t        wr_match_way;
	logic        wr_free;
	way_t        wr_free_way;
	way_t        wr_low_way;

	logic [AGE_W-1:0] age_cnt;
	logic        age_tick;
	logic        age_step;

	assign lk_set = lookup_addr[OFFSET_W +: INDEX_W];
	assign lk_tag = lookup_addr[ADDR_W-1 -: TAG_W];
	assign wr_set = wr_addr[OFFSET_W +: INDEX_W];
	assign wr_tag = wr_addr[ADDR_W-1 -: TAG_W];

	// Lookup compare, scanned downward so the lowest way wins
	always_comb begin
		lk_hit = 1'b0;
		lk_way = '0;
		for (int w = WAY_N-1; w >= 0; w--) begin
			if (tag_mem[lk_set][w] == lk_tag && status[lk_set][w] != ST_INVALID) begin
				lk_hit = 1'b1;
				lk_way = way_t'(w);
			end
		end
	end

	// Fill way: same tag, then first free way, then lowest status
	always_comb begin
		wr_match     = 1'b0;
		wr_match_way = '0;
		wr_free      = 1'b0;
		wr_free_way  = '0;
		for (int w = WAY_N-1; w >= 0; w--) begin
			if (tag_mem[wr_set][w] == wr_tag && status[wr_set][w] != ST_INVALID) begin
				wr_match     = 1'b1;
				wr_match_way = way_t'(w);
			end
			if (status[wr_set][w] == ST_INVALID) begin
				wr_free      = 1'b1;
				wr_free_way  = way_t'(w);
			end
		end
		wr_low_way = '0;
		for (int w = 1; w < WAY_N; w++) begin
			if (status[wr_set][w] < status[wr_set][wr_low_way])
				wr_low_way = way_t'(w);	// Strict less keeps ties on the lower way
		end
	end

	assign fill_way = wr_match ? wr_match_way : (wr_free ? wr_free_way : wr_low_way);

	// Aging waits out a fill that lands on the tick
	assign age_tick = (age_cnt == AGE_W'(AGE_PERIOD-1));
	assign age_step = age_tick && !wr_req;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			age_cnt <= '0;
		end else if (remove || age_step) begin
			age_cnt <= '0;
		end else if (!age_tick) begin
			age_cnt <= age_cnt + 1'b1;
		end
	end

	// Lookup result, lined up with the data read in l1_line_ram
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			hit     <= 1'b0;
			hit_way <= '0;
		end else begin
			hit     <= lookup_en && lk_hit;
			hit_way <= lk_way;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int s = 0; s < SET_N; s++)
				for (int w = 0; w < WAY_N; w++)
					status[s][w] <= ST_INVALID;
		end else if (remove) begin
			for (int s = 0; s < SET_N; s++)
				for (int w = 0; w < WAY_N; w++)
					status[s][w] <= ST_INVALID;
		end else begin
			if (age_step) begin
				for (int s = 0; s < SET_N; s++) begin
					for (int w = 0; w < WAY_N; w++) begin
						if (status[s][w] == ST_RECENT || status[s][w] == ST_FRESH)
							status[s][w] <= way_status_e'(status[s][w] - 2'd1);
					end
				end
			end
			// Touch wins over the aging step for the same way
			if (lookup_en && lk_hit)
				status[lk_set][lk_way] <= ST_FRESH;
			if (wr_req)
				status[wr_set][fill_way] <= ST_FRESH;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (wr_req)
			tag_mem[wr_set][fill_way] <= wr_tag;
	end

endmodule

/* hdl/l1_line_ram.sv */
// Way data arrays with one line fill port and a registered read of all ways
`timescale 1ns/10ps

module l1_line_ram (
	input  logic                  iCLOCK,
	input  logic                  wr_req,
	input  cache_geom_pkg::way_t  fill_way,
	input  cache_geom_pkg::addr_t wr_addr,
	input  cache_geom_pkg::line_t wr_line,
	input  logic                  lookup_en,
	input  cache_geom_pkg::addr_t lookup_addr,
	output cache_geom_pkg::line_t way_lines [cache_geom_pkg::WAY_N]
);
	import cache_geom_pkg::*;

	line_t    mem [WAY_N][SET_N];

	set_idx_t wr_set;
	set_idx_t lk_set;

	assign wr_set = wr_addr[OFFSET_W +: INDEX_W];
	assign lk_set = lookup_addr[OFFSET_W +: INDEX_W];

	// Whole line in one cycle
	always_ff @(posedge iCLOCK) begin
		if (wr_req)
			mem[fill_way][wr_set] <= wr_line;
	end

	// All ways read at once, the way is picked a stage later
	always_ff @(posedge iCLOCK) begin
		if (lookup_en) begin
			for (int w = 0; w < WAY_N; w++)
				way_lines[w] <= mem[w][lk_set];
		end
	end

endmodule

/* hdl/l1_read_response.sv */
// Read credit counter, request acceptance, way and word select, registered read response
`timescale 1ns/10ps

module l1_read_response (
	input  logic                  iCLOCK,
	input  logic                  inRESET,
	input  logic                  rd_req,
	input  cache_geom_pkg::addr_t rd_addr,
	input  logic                  wr_req,
	input  logic                  rd_credit,
	input  logic                  hit,
	input  cache_geom_pkg::way_t  hit_way,
	input  cache_geom_pkg::line_t way_lines [cache_geom_pkg::WAY_N],
	output logic                  rd_ready,
	output logic                  lookup_en,
	output cache_geom_pkg::addr_t lookup_addr,
	output logic                  rd_valid,
	output logic                  rd_hit,
	output cache_geom_pkg::word_t rd_data
);
	import cache_geom_pkg::*;
	import cache_ctrl_pkg::*;

	logic [CREDIT_W-1:0] credit_cnt;
	logic                accept;

	logic                s1_valid;
	word_sel_t           s1_word;
	line_t               sel_line;
	word_t               sel_word;

	// A fill owns the cycle
	assign rd_ready    = (credit_cnt != '0) && !wr_req;
	assign accept      = rd_req && rd_ready;
	assign lookup_en   = accept;
	assign lookup_addr = rd_addr;

	// One credit spent per accepted read
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			credit_cnt <= CREDIT_W'(CREDIT_N);
		end else begin
			case ({accept, rd_credit})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;	// Both or neither
			endcase
		end
	end

	// Stage 1 bookkeeping
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET)
			s1_valid <= 1'b0;
		else
			s1_valid <= accept;
	end

	always_ff @(posedge iCLOCK) begin
		if (accept)
			s1_word <= rd_addr[OFFSET_W-1 -: WORD_SEL_W];
	end

	assign sel_line = way_lines[hit_way];
	assign sel_word = sel_line[s1_word * $bits(word_t) +: $bits(word_t)];

	// Stage 2, data forced to zero on a miss
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rd_valid <= 1'b0;
			rd_hit   <= 1'b0;
			rd_data  <= '0;
		end else begin
			rd_valid <= s1_valid;
			rd_hit   <= s1_valid && hit;
			rd_data  <= (s1_valid && hit) ? sel_word : '0;
		end
	end

endmodule

/* hdl/l1_cache_top.sv */
// L1 read cache top level: read response, tag store and line RAM
`timescale 1ns/10ps

module l1_cache_top (
	input  logic                  iCLOCK,
	input  logic                  inRESET,
	input  logic                  remove,
	// Line fill
	input  logic                  wr_req,
	input  cache_geom_pkg::addr_t wr_addr,
	input  cache_geom_pkg::line_t wr_line,
	// Read request
	input  logic                  rd_req,
	input  cache_geom_pkg::addr_t rd_addr,
	output logic                  rd_ready,
	// Read response
	input  logic                  rd_credit,
	output logic                  rd_valid,
	output logic                  rd_hit,
	output cache_geom_pkg::word_t rd_data
);
	import cache_geom_pkg::*;

	logic  lookup_en;
	addr_t lookup_addr;
	logic  hit;
	way_t  hit_way;
	way_t  fill_way;
	line_t way_lines [WAY_N];

	l1_read_response u_read_response (
		.iCLOCK      (iCLOCK),
		.inRESET     (inRESET),
		.rd_req      (rd_req),
		.rd_addr     (rd_addr),
		.wr_req      (wr_req),
		.rd_credit   (rd_credit),
		.hit         (hit),
		.hit_way     (hit_way),
		.way_lines   (way_lines),
		.rd_ready    (rd_ready),
		.lookup_en   (lookup_en),
		.lookup_addr (lookup_addr),
		.rd_valid    (rd_valid),
		.rd_hit      (rd_hit),
		.rd_data     (rd_data)
	);

	l1_tag_store u_tag_store (
		.iCLOCK      (iCLOCK),
		.inRESET     (inRESET),
		.remove      (remove),
		.lookup_en   (lookup_en),
		.lookup_addr (lookup_addr),
		.wr_req      (wr_req),
		.wr_addr     (wr_addr),
		.hit         (hit),
		.hit_way     (hit_way),
		.fill_way    (fill_way)
	);

	l1_line_ram u_line_ram (
		.iCLOCK      (iCLOCK),
		.wr_req      (wr_req),
		.fill_way    (fill_way),
		.wr_addr     (wr_addr),
		.wr_line     (wr_line),
		.lookup_en   (lookup_en),
		.lookup_addr (lookup_addr),
		.way_lines   (way_lines)
	);

endmodule

/* bench/l1_cache_checker.sv */
// Bound assertions on the fill, read request and read response ports of the cache top level
`timescale 1ns/10ps

module l1_cache_checker (
	input logic                  iCLOCK,
	input logic                  inRESET,
	input logic                  wr_req,
	input logic                  rd_req,
	input logic                  rd_ready,
	input logic                  rd_valid,
	input logic                  rd_hit,
	input cache_geom_pkg::word_t rd_data
);

	int fail_count = 0;	// Failed assertions so far

	// A hit flag only comes with a response
	a_hit_needs_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		rd_hit |-> rd_valid)
		else begin
			fail_count++;
			$error("rd_hit high without rd_valid");
		end

	// Miss data is forced to zero
	a_miss_data_zero: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!rd_hit |-> (rd_data == '0))
		else begin
			fail_count++;
			$error("rd_data nonzero while rd_hit is low");
		end

	// Fixed two cycle pipeline
	a_accept_to_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(rd_req && rd_ready) |-> ##2 rd_valid)
		else begin
			fail_count++;
			$error("accepted read gave no rd_valid two cycles later");
		end

	a_fill_blocks_read: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		wr_req |-> !rd_ready)
		else begin
			fail_count++;
			$error("rd_ready high during a fill");
		end

endmodule

/* bench/l1_cache_tb.sv */
// L1 cache testbench with clock, reset, directed fill, read, credit and remove tests and summary
`timescale 1ns/10ps

module l1_cache_tb;
	import cache_geom_pkg::*;
	import cache_ctrl_pkg::*;

	localparam int CLK_PERIOD    = 8;
	localparam int RESET_CYCLES  = 16;
	localparam int READY_TIMEOUT = 50;
	localparam int VALID_TIMEOUT = 10;

	logic  iCLOCK;
	logic  inRESET;
	logic  remove;
	logic  wr_req;
	addr_t wr_addr;
	line_t wr_line;
	logic  rd_req;
	addr_t rd_addr;
	logic  rd_ready;
	logic  rd_credit;
	logic  rd_valid;
	logic  rd_hit;
	word_t rd_data;

	string test_name;
	int    test_errors;
	int    total_errors;
	int    tests_run;
	addr_t filled_addrs [$];	// Every fill address so far

	l1_cache_top UUT (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.remove    (remove),
		.wr_req    (wr_req),
		.wr_addr   (wr_addr),
		.wr_line   (wr_line),
		.rd_req    (rd_req),
		.rd_addr   (rd_addr),
		.rd_ready  (rd_ready),
		.rd_credit (rd_credit),
		.rd_valid  (rd_valid),
		.rd_hit    (rd_hit),
		.rd_data   (rd_data)
	);

	bind l1_cache_top l1_cache_checker u_checker (
		.iCLOCK   (iCLOCK),
		.inRESET  (inRESET),
		.wr_req   (wr_req),
		.rd_req   (rd_req),
		.rd_ready (rd_ready),
		.rd_valid (rd_valid),
		.rd_hit   (rd_hit),
		.rd_data  (rd_data)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #(CLK_PERIOD/2) iCLOCK = ~iCLOCK;
	end

	// Byte address built from the tag, set and word fields
	function automatic addr_t make_addr(tag_t tag, set_idx_t set, word_sel_t word);
		return {tag, set, word, 3'b000};
	endfunction

	function automatic line_t random_line();
		line_t l;
		for (int i = 0; i < $bits(line_t) / 32; i++)
			l[i*32 +: 32] = $urandom;
		return l;
	endfunction

	function automatic word_t line_word(line_t l, int w);
		return l[w*64 +: 64];	// Word 0 in the low bits
	endfunction

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = 0;
		tests_run++;
	endtask

	task automatic finish_test();
		if (test_errors == 0)
			$display("test %s: ok", test_name);
		else
			$display("test %s: %0d errors", test_name, test_errors);
		total_errors += test_errors;
	endtask

	task automatic report_failure(input string what);
		$display("%s: %s", test_name, what);
		test_errors++;
	endtask

	task automatic compare_hit(input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("error %s: rd_hit expected %b, actual %b", test_name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic compare_word(input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("error %s: rd_data expected %h, actual %h", test_name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic compare_flag(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("error %s: %s expected %b, actual %b", test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_count(input string what, input int expected, input int actual);
		if (actual != expected) begin
			$display("error %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic fill_line(input addr_t addr, input line_t line);
		@(negedge iCLOCK);
		wr_req  = 1'b1;
		wr_addr = addr;
		wr_line = line;
		@(negedge iCLOCK);
		wr_req  = 1'b0;
		filled_addrs.push_back(addr);
	endtask

	// One credit per rising edge while held
	task automatic return_credits(input int n);
		rd_credit = 1'b1;
		repeat (n) @(negedge iCLOCK);
		rd_credit = 1'b0;
	endtask

	task automatic read_word(input addr_t addr, output logic hit, output word_t data);
		int n;
		hit  = 1'b0;
		data = '0;
		@(negedge iCLOCK);
		rd_req  = 1'b1;
		rd_addr = addr;
		#2;	// rd_ready settles in the low phase
		n = 0;
		while (!rd_ready && n < READY_TIMEOUT) begin
			@(negedge iCLOCK);
			#2;
			n++;
		end
		if (!rd_ready) begin
			report_failure("rd_ready stayed low, the read was never accepted");
			rd_req = 1'b0;
		end else begin
			@(negedge iCLOCK);	// Accepted on the rising edge before
			rd_req = 1'b0;
			n = 0;
			while (!rd_valid && n < VALID_TIMEOUT) begin
				@(negedge iCLOCK);
				n++;
			end
			if (!rd_valid) begin
				report_failure("no rd_valid came after an accepted read");
			end else begin
				hit  = rd_hit;
				data = rd_data;
				return_credits(1);
			end
		end
	endtask

	task automatic check_read(input addr_t addr, input logic exp_hit, input word_t exp_data);
		logic  hit;
		word_t data;
		read_word(addr, hit, data);
		compare_hit(exp_hit, hit);
		compare_word(exp_hit ? exp_data : word_t'(0), data);
	endtask

	task automatic miss_after_reset();
		start_test("miss after reset");
		compare_flag("rd_ready after reset", 1'b1, rd_ready);
		compare_flag("rd_valid after reset", 1'b0, rd_valid);
		compare_hit(1'b0, rd_hit);
		compare_word('0, rd_data);
		for (int i = 0; i < 3; i++)
			check_read(addr_t'($urandom), 1'b0, '0);
		finish_test();
	endtask

	task automatic fill_then_read();
		tag_t  tag;
		line_t line;
		start_test("fill then read");
		tag  = tag_t'($urandom);
		line = random_line();
		fill_line(make_addr(tag, 4'd3, '0), line);
		for (int w = 0; w < 8; w++)
			check_read(make_addr(tag, 4'd3, word_sel_t'(w)), 1'b1, line_word(line, w));
		finish_test();
	endtask

	task automatic refill_same_tag();
		tag_t  base;
		line_t lines [WAY_N];
		start_test("refill same tag");
		base = tag_t'($urandom);
		for (int i = 0; i < WAY_N; i++) begin
			lines[i] = random_line();
			fill_line(make_addr(base + tag_t'(i), 4'd5, '0), lines[i]);
		end
		lines[1] = random_line();	// New data for the same tag
		fill_line(make_addr(base + tag_t'(1), 4'd5, '0), lines[1]);
		for (int w = 0; w < 8; w++)
			check_read(make_addr(base + tag_t'(1), 4'd5, word_sel_t'(w)), 1'b1,
				line_word(lines[1], w));
		for (int i = 0; i < WAY_N; i++)
			check_read(make_addr(base + tag_t'(i), 4'd5, 3'd6), 1'b1, line_word(lines[i], 6));
		finish_test();
	endtask

	task automatic evict_oldest_way();
		tag_t  base;
		line_t lines [5];
		start_test("replacement");
		base = tag_t'($urandom);
		for (int i = 0; i < 4; i++) begin
			lines[i] = random_line();
			fill_line(make_addr(base + tag_t'(i), 4'd9, '0), lines[i]);
		end
		repeat (2 * AGE_PERIOD + 8) @(negedge iCLOCK);	// Two aging steps bring all ways to old
		check_read(make_addr(base + tag_t'(1), 4'd9, 3'd2), 1'b1, line_word(lines[1], 2));
		lines[4] = random_line();
		fill_line(make_addr(base + tag_t'(4), 4'd9, '0), lines[4]);
		check_read(make_addr(base, 4'd9, 3'd0), 1'b0, '0);	// Oldest lowest way evicted
		for (int i = 1; i < 5; i++)
			check_read(make_addr(base + tag_t'(i), 4'd9, 3'd5), 1'b1, line_word(lines[i], 5));
		finish_test();
	endtask

	task automatic credit_limit();
		int accepted;
		int responses;
		start_test("credits");
		accepted  = 0;
		responses = 0;
		@(negedge iCLOCK);
		rd_req  = 1'b1;
		rd_addr = addr_t'($urandom);
		repeat (12) begin	// No credits returned in this window
			#2;
			if (rd_ready)
				accepted++;
			@(negedge iCLOCK);
			if (rd_valid)
				responses++;
		end
		check_count("reads accepted without credit return", CREDIT_N, accepted);
		check_count("responses without credit return", CREDIT_N, responses);
		compare_flag("rd_ready with no credits left", 1'b0, rd_ready);
		accepted  = 0;
		responses = 0;
		rd_credit = 1'b1;
		repeat (8) begin
			#2;
			if (rd_ready)
				accepted++;
			@(negedge iCLOCK);
			rd_credit = 1'b0;	// Single pulse
			if (rd_valid)
				responses++;
		end
		rd_req = 1'b0;
		check_count("reads accepted after one credit", 1, accepted);
		check_count("responses after one credit", 1, responses);
		return_credits(CREDIT_N);
		#2;
		compare_flag("rd_ready after all credits came back", 1'b1, rd_ready);
		finish_test();
	endtask

	task automatic remove_all_lines();
		tag_t  base;
		line_t line;
		start_test("remove");
		base = tag_t'($urandom);
		for (int i = 0; i < 3; i++) begin
			line = random_line();
			fill_line(make_addr(base + tag_t'(i), set_idx_t'(12 + i), '0), line);
		end
		check_read(make_addr(base + tag_t'(2), 4'd14, 3'd0), 1'b1, line_word(line, 0));
		@(negedge iCLOCK);
		remove = 1'b1;
		@(negedge iCLOCK);
		remove = 1'b0;
		foreach (filled_addrs[i])
			check_read(filled_addrs[i], 1'b0, '0);
		finish_test();
	endtask

	initial begin
		void'($urandom(32'h4b6f));
		inRESET      = 1'b0;
		remove       = 1'b0;
		wr_req       = 1'b0;
		wr_addr      = '0;
		wr_line      = '0;
		rd_req       = 1'b0;
		rd_addr      = '0;
		rd_credit    = 1'b0;
		test_errors  = 0;
		total_errors = 0;
		tests_run    = 0;
		repeat (RESET_CYCLES) @(negedge iCLOCK);
		inRESET = 1'b1;

		miss_after_reset();
		fill_then_read();
		refill_same_tag();
		evict_oldest_way();
		credit_limit();
		remove_all_lines();

		total_errors += UUT.u_checker.fail_count;	// Assertion failures count too
		$display("%0d tests run, %0d checks failed", tests_run, total_errors);
		if (total_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* files.f */
hdl/cache_geom_pkg.sv
hdl/cache_ctrl_pkg.sv
hdl/l1_tag_store.sv
hdl/l1_line_ram.sv
hdl/l1_read_response.sv
hdl/l1_cache_top.sv
bench/l1_cache_checker.sv
bench/l1_cache_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the L1 cache testbench with Verilator, runs it and checks the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module l1_cache_tb \
	-f files.f \
	--Mdir obj_dir -o l1_cache_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/l1_cache_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
